/* cfg_space/cfg_read_mux.sv */
`include "ahb_cfg_defs.svh"

module cfg_read_mux
   import ahb_cfg_pkg::*;
(
   input  logic      hclk,
   input  logic      hresetn,
   input  logic      rd_load,
   input  reg_addr_t rd_addr,
   input  hdata_t    desc_words [2*`CFG_NUM_SLV],
   output hdata_t    hrdata
);

   localparam int desc_aw = $clog2(2*`CFG_NUM_SLV);

   word_idx_t            word_idx;
   page_t                page;
   logic [desc_aw-1:0]   desc_sel;
   logic                 desc_hit;
   hdata_t               rd_word;

   assign word_idx = rd_addr[6:0];
   assign page     = rd_addr[9:7];

   // offset into the descriptor table
   assign desc_sel = desc_aw'(word_idx - word_idx_t'(`CFG_DESC_WORD));
   assign desc_hit = (word_idx >= word_idx_t'(`CFG_DESC_WORD)) &&
                     (word_idx <  word_idx_t'(`CFG_DESC_WORD + 2*`CFG_NUM_SLV));

   // ----------------------------------------------------------------------
   // word select, only page 0 is populated
   // ----------------------------------------------------------------------
   always_comb begin
      rd_word = '0;
      if (page == '0) begin
         if (word_idx == '0)
            rd_word = `CFG_PRODUCT_ID;
         else if (desc_hit)
            rd_word = desc_words[desc_sel];
      end
   end

   // read data stage, holds between loads
   always_ff @(posedge hclk or negedge hresetn) begin
      if (!hresetn)
         hrdata <= '0;
      else if (rd_load)
         hrdata <= rd_word;
   end

endmodule

/* cfg_space/region_desc_table.sv */
`include "ahb_cfg_defs.svh"

module region_desc_table
   import ahb_cfg_pkg::*;
(
   output hdata_t desc_words [2*`CFG_NUM_SLV]
);

   // ----------------------------------------------------------------------
   // per-slave configuration, slave 0 in the low slot
   // ----------------------------------------------------------------------
   localparam logic [`CFG_NUM_SLV-1:0][63:0] base_cfg = {
      `CFG_SLV7_BASE, `CFG_SLV6_BASE, `CFG_SLV5_BASE, `CFG_SLV4_BASE,
      `CFG_SLV3_BASE, `CFG_SLV2_BASE, `CFG_SLV1_BASE, `CFG_SLV0_BASE
   };

   localparam logic [`CFG_NUM_SLV-1:0][7:0] size_cfg = {
      `CFG_SLV7_SIZE, `CFG_SLV6_SIZE, `CFG_SLV5_SIZE, `CFG_SLV4_SIZE,
      `CFG_SLV3_SIZE, `CFG_SLV2_SIZE, `CFG_SLV1_SIZE, `CFG_SLV0_SIZE
   };

   localparam logic [`CFG_NUM_SLV-1:0] support = `CFG_SLV_SUPPORT;

   // bits at or above the system address width never decode
   localparam logic [63:0] addr_keep = (64'd1 << `CFG_ADDR_WIDTH) - 64'd1;

   // ----------------------------------------------------------------------
   // descriptor pair per slave
   // ----------------------------------------------------------------------
   for (genvar k = 0; k < `CFG_NUM_SLV; k++) begin : g_slv
      // base must be aligned to the region size
      localparam int          shamt     = int'(size_cfg[k]) + 19;
      localparam logic [63:0] size_keep = ~64'd0 << shamt;

      slv_base_t base;
      slv_size_t size;

      assign size = size_cfg[k];
      assign base = slv_base_t'((base_cfg[k] & size_keep & addr_keep) >> 20);

      // low word: base[31:20], reserved, size code
      assign desc_words[2*k]   = support[k] ? {base[11:0], 12'h000, size} : '0;
      // high word: base[63:32]
      assign desc_words[2*k+1] = support[k] ? base[43:12] : '0;
   end

endmodule

/* common/ahb_cfg_defs.svh */
`ifndef AHB_CFG_DEFS_SVH
`define AHB_CFG_DEFS_SVH

// product id word, read at word 0
`define CFG_PRODUCT_ID     32'h0b57_1a03

`define CFG_ADDR_WIDTH     40            // system address width
`define CFG_NUM_SLV        8             // slave ports in the matrix
`define CFG_SLV_SUPPORT    8'b1011_0111  // bit k enables slave k

// ----------------------------------------------------------------------
// raw slave base addresses, masked in hardware
// ----------------------------------------------------------------------
`define CFG_SLV0_BASE      64'h0000_0000_0000_0000
`define CFG_SLV1_BASE      64'h0000_0000_8012_3456
`define CFG_SLV2_BASE      64'h0000_00f1_2340_0000
`define CFG_SLV3_BASE      64'h0000_0000_c000_0000
`define CFG_SLV4_BASE      64'hffff_ff80_0000_0000
`define CFG_SLV5_BASE      64'h0000_0000_e7ff_ffff
`define CFG_SLV6_BASE      64'h0000_0012_0000_0000
`define CFG_SLV7_BASE      64'h0000_1234_5678_9abc

// size codes, region is 2^(code+19) bytes
`define CFG_SLV0_SIZE      8'h0b
`define CFG_SLV1_SIZE      8'h05
`define CFG_SLV2_SIZE      8'h01
`define CFG_SLV3_SIZE      8'h09
`define CFG_SLV4_SIZE      8'h14
`define CFG_SLV5_SIZE      8'h00
`define CFG_SLV6_SIZE      8'h0d
`define CFG_SLV7_SIZE      8'h03

`define CFG_RAW_WORD       4             // word with write-then-read stall
`define CFG_DESC_WORD      64            // first descriptor word

`endif

/* common/ahb_cfg_pkg.sv */
package ahb_cfg_pkg;

   // ----------------------------------------------------------------------
   // bus side
   // ----------------------------------------------------------------------
   typedef logic [31:0] haddr_t;      // ahb byte address
   typedef logic [31:0] hdata_t;      // one data word

   // ----------------------------------------------------------------------
   // configuration space addressing
   // ----------------------------------------------------------------------
   typedef logic [6:0]  word_idx_t;   // haddr[8:2]
   typedef logic [2:0]  page_t;       // haddr[11:9]
   typedef logic [9:0]  reg_addr_t;   // haddr[11:2]

   // descriptor fields
   typedef logic [43:0] slv_base_t;   // base address bits 63:20
   typedef logic [7:0]  slv_size_t;   // region size code

endpackage

/* filelist.f */
+incdir+common
common/ahb_cfg_pkg.sv
hdl/ahb_xfer_ctrl.sv
cfg_space/region_desc_table.sv
cfg_space/cfg_read_mux.sv
hdl/ahb_cfg_top.sv
tb/tb_clkgen.sv
tb/ahb_cfg_asserts.sv
tb/ahb_cfg_tb.sv

/* hdl/ahb_cfg_top.sv */
`include "ahb_cfg_defs.svh"

module ahb_cfg_top
   import ahb_cfg_pkg::*;
(
   input  logic       hclk,
   input  logic       hresetn,
   input  logic       hsel,
   input  logic [1:0] htrans,
   input  logic       hwrite,
   input  haddr_t     haddr,
   input  logic [2:0] hsize,      // only 32-bit transfers are served
   input  hdata_t     hwdata,     // read-only space, write data dropped
   input  logic       hready_in,
   output logic       hready,
   output logic [1:0] hresp,
   output hdata_t     hrdata
);

   logic      rd_load;
   reg_addr_t rd_addr;
   hdata_t    desc_words [2*`CFG_NUM_SLV];

   // address phase qualification and raw stall
   ahb_xfer_ctrl ahb_xfer_ctrl_i (
      .hclk      (hclk),
      .hresetn   (hresetn),
      .hsel      (hsel),
      .htrans    (htrans),
      .hwrite    (hwrite),
      .haddr     (haddr),
      .hready_in (hready_in),
      .hready    (hready),
      .hresp     (hresp),
      .rd_load   (rd_load),
      .rd_addr   (rd_addr)
   );

   // constant descriptor words
   region_desc_table region_desc_table_i (
      .desc_words (desc_words)
   );

   cfg_read_mux cfg_read_mux_i (
      .hclk       (hclk),
      .hresetn    (hresetn),
      .rd_load    (rd_load),
      .rd_addr    (rd_addr),
      .desc_words (desc_words),
      .hrdata     (hrdata)
   );

endmodule

/* hdl/ahb_xfer_ctrl.sv */
`include "ahb_cfg_defs.svh"

module ahb_xfer_ctrl
   import ahb_cfg_pkg::*;
(
   input  logic       hclk,
   input  logic       hresetn,
   input  logic       hsel,
   input  logic [1:0] htrans,
   input  logic       hwrite,
   input  haddr_t     haddr,
   input  logic       hready_in,
   output logic       hready,
   output logic [1:0] hresp,
   output logic       rd_load,
   output reg_addr_t  rd_addr
);

   logic      xfer_ok;      // nonseq or seq, slave selected, bus ready
   logic      ren;
   logic      wen;
   logic      raw_hit;      // live address is the stall word
   logic      wr_raw_q;     // last accepted transfer wrote the stall word
   logic      stall_q;
   reg_addr_t haddr_q;      // address of the previous cycle

   // ----------------------------------------------------------------------
   // transfer qualification
   // ----------------------------------------------------------------------
   assign xfer_ok = hsel & hready_in & htrans[1];
   assign ren     = xfer_ok & ~hwrite;
   assign wen     = xfer_ok & hwrite;
   assign raw_hit = (haddr[11:2] == reg_addr_t'(`CFG_RAW_WORD));

   always_ff @(posedge hclk or negedge hresetn) begin
      if (!hresetn) begin
         wr_raw_q <= 1'b0;
         stall_q  <= 1'b0;
      end else begin
         wr_raw_q <= wen & raw_hit;
         stall_q  <= ren & raw_hit & wr_raw_q;  // read right behind the write
      end
   end

   // held for the replay in the stall cycle
   always_ff @(posedge hclk) begin
      haddr_q <= haddr[11:2];
   end

   // ----------------------------------------------------------------------
   // response and read request
   // ----------------------------------------------------------------------
   assign hready = ~stall_q;
   assign hresp  = 2'b00;                       // always okay

   assign rd_load = ren | stall_q;
   assign rd_addr = stall_q ? haddr_q : haddr[11:2];

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the AHB configuration block testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   -f filelist.f \
   --top-module ahb_cfg_tb \
   -o ahb_cfg_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/ahb_cfg_sim 2>&1)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
   echo "simulator exited with status $sim_status"
   exit 1
fi

if grep -q "^TEST PASSED$" <<< "$sim_out"; then
   exit 0
fi

echo "pass message not found"
exit 1

/* tb/ahb_cfg_asserts.sv */
module ahb_cfg_asserts (
   input logic       hclk,
   input logic       hresetn,
   input logic       hready,
   input logic [1:0] hresp
);

   timeunit 1ns;
   timeprecision 1ps;

   // read-only space, every response is okay
   hresp_okay: assert property (@(posedge hclk) disable iff (!hresetn) hresp == 2'b00)
      else $error("hresp not okay");

   // the stall lasts a single cycle
   stall_one_cycle: assert property (@(posedge hclk) disable iff (!hresetn) !hready |=> hready)
      else $error("hready low for two cycles");

   ready_after_reset: assert property (@(posedge hclk) $rose(hresetn) |-> hready)
      else $error("hready low right after reset");

endmodule

bind ahb_cfg_top ahb_cfg_asserts ahb_cfg_asserts_i (
   .hclk    (hclk),
   .hresetn (hresetn),
   .hready  (hready),
   .hresp   (hresp)
);

/* tb/ahb_cfg_tb.sv */
`include "ahb_cfg_defs.svh"

module ahb_cfg_tb
   import ahb_cfg_pkg::*;
;

   timeunit 1ns;
   timeprecision 1ps;

   // 400 transfers of at most 3 cycles plus reset and margin
   localparam int max_cycles = 2000;

   logic       hclk;
   logic       hresetn;
   logic       hsel;
   logic [1:0] htrans;
   logic       hwrite;
   haddr_t     haddr;
   logic [2:0] hsize;
   hdata_t     hwdata;
   logic       hready;
   logic [1:0] hresp;
   hdata_t     hrdata;

   int     cycles = 0;
   int     checks = 0;
   int     errors = 0;
   int     test_err;
   int     total_stalls = 0;
   hdata_t exp_rdata = '0;    // hrdata after the last accepted read
   int     exp_stall = 0;
   logic   last_wr4 = 1'b0;

   tb_clkgen tb_clkgen_i (.hclk(hclk), .hresetn(hresetn));

   ahb_cfg_top ahb_cfg_top_i (
      .hclk      (hclk),
      .hresetn   (hresetn),
      .hsel      (hsel),
      .htrans    (htrans),
      .hwrite    (hwrite),
      .haddr     (haddr),
      .hsize     (hsize),
      .hwdata    (hwdata),
      .hready_in (hready),     // ready fed back from the only slave
      .hready    (hready),
      .hresp     (hresp),
      .hrdata    (hrdata)
   );

   always @(posedge hclk) begin
      cycles <= cycles + 1;
      if (cycles >= max_cycles) begin
         $display("timeout, run stopped after %0d cycles", cycles);
         $display("TEST FAILED");
         $finish;
      end
   end

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("** Error: %s got %h expected %h", name, got, exp);
      end
   endtask

   // ----------------------------------------------------------------------
   // reference model
   // ----------------------------------------------------------------------
   function automatic hdata_t expected_word(haddr_t addr);
      logic [7:0]  sup = `CFG_SLV_SUPPORT;
      logic [63:0] base;
      logic [7:0]  size;
      int          off;
      int          k;
      if (addr[11:9] != 3'd0)
         return '0;
      if (addr[8:2] == 7'd0)
         return `CFG_PRODUCT_ID;
      off = int'(addr[8:2]) - `CFG_DESC_WORD;
      if (off < 0 || off >= 2*`CFG_NUM_SLV)
         return '0;
      k = off / 2;
      if (!sup[k])
         return '0;
      case (k)
         0: begin base = `CFG_SLV0_BASE; size = `CFG_SLV0_SIZE; end
         1: begin base = `CFG_SLV1_BASE; size = `CFG_SLV1_SIZE; end
         2: begin base = `CFG_SLV2_BASE; size = `CFG_SLV2_SIZE; end
         3: begin base = `CFG_SLV3_BASE; size = `CFG_SLV3_SIZE; end
         4: begin base = `CFG_SLV4_BASE; size = `CFG_SLV4_SIZE; end
         5: begin base = `CFG_SLV5_BASE; size = `CFG_SLV5_SIZE; end
         6: begin base = `CFG_SLV6_BASE; size = `CFG_SLV6_SIZE; end
         default: begin base = `CFG_SLV7_BASE; size = `CFG_SLV7_SIZE; end
      endcase
      base = base & ~((64'd1 << (int'(size) + 19)) - 64'd1);   // align to region
      base = base & ((64'd1 << `CFG_ADDR_WIDTH) - 64'd1);
      if (off % 2 == 1)
         return base[63:32];
      return {base[31:20], 12'h000, size};
   endfunction

   function automatic haddr_t make_addr(logic [2:0] page, logic [6:0] idx);
      logic [31:0] r;
      r = $urandom;
      return {r[31:12], page, idx, 2'b00};
   endfunction

   function automatic haddr_t rand_unused_addr();
      int unsigned r;
      r = $urandom_range(1, 111);
      if (r >= 64)
         r = r + 16;                // skip the descriptor words
      return make_addr(3'd0, 7'(r));
   endfunction

   function automatic haddr_t rand_desc_addr();
      return make_addr(3'd0, 7'(`CFG_DESC_WORD + $urandom_range(0, 15)));
   endfunction

   function automatic haddr_t rand_page_addr();
      return make_addr(3'(1 + $urandom_range(0, 6)), 7'($urandom_range(0, 127)));
   endfunction

   // ----------------------------------------------------------------------
   // one transfer of the given kind (0 idle, 1 read, 2 write)
   // checks the previous data phase while this address phase waits
   // ----------------------------------------------------------------------
   task automatic xfer(input int kind, input haddr_t addr);
      int          stalls;
      logic        hit4;
      logic [31:0] r;
      stalls = 0;
      r      = $urandom;
      hit4   = (addr[11:2] == 10'(`CFG_RAW_WORD));
      // an idle is either unselected with an active htrans or selected idle/busy
      hsel   <= (kind != 0) || r[1];
      htrans <= {(kind != 0) || !r[1], r[0]};
      hwrite <= (kind == 2);
      haddr  <= addr;
      hsize  <= 3'b010;
      hwdata <= $urandom;
      @(negedge hclk);
      check("hrdata", hrdata, exp_rdata);
      while (hready !== 1'b1) begin
         stalls++;
         @(negedge hclk);
      end
      total_stalls += stalls;
      check("stall cycles", 32'(stalls), 32'(exp_stall));
      @(posedge hclk);             // accepted here
      exp_stall = (last_wr4 && kind == 1 && hit4) ? 1 : 0;
      last_wr4  = (kind == 2) && hit4;
      if (kind == 1)
         exp_rdata = expected_word(addr);
   endtask

   task automatic report(input string name);
      $display("test %-12s %0d errors", name, errors - test_err);
      test_err = errors;
   endtask

   initial begin
      int kind;
      int sel;
      haddr_t a;
      void'($urandom(32'h56f1b4e7));
      hsel   = 1'b0;
      htrans = 2'b00;
      hwrite = 1'b0;
      haddr  = '0;
      hsize  = 3'b010;
      hwdata = '0;
      test_err = 0;

      @(posedge hresetn);
      @(negedge hclk);
      check("hready", 32'(hready), 32'h1);
      check("hresp", 32'(hresp), 32'h0);
      check("hrdata", hrdata, 32'h0);
      @(posedge hclk);
      report("reset");

      for (int i = 0; i < 4; i++)
         xfer(1, make_addr(3'd0, 7'd0));
      report("product_id");

      for (int i = 0; i < 16; i++)
         xfer(1, make_addr(3'd0, 7'(`CFG_DESC_WORD + i)));
      for (int i = 0; i < 24; i++)
         xfer(1, rand_desc_addr());
      report("descriptors");

      for (int i = 0; i < 20; i++)
         xfer(1, rand_unused_addr());
      for (int i = 0; i < 20; i++)
         xfer(1, rand_page_addr());
      report("zero_regions");

      // write then read of word 4 stalls but other words do not
      total_stalls = 0;
      xfer(2, make_addr(3'd0, 7'(`CFG_RAW_WORD)));
      xfer(1, make_addr(3'd0, 7'(`CFG_RAW_WORD)));
      xfer(0, '0);
      xfer(2, make_addr(3'd0, 7'(`CFG_RAW_WORD)));
      xfer(1, make_addr(3'd0, 7'd0));
      xfer(0, '0);
      check("total stalls", 32'(total_stalls), 32'h1);
      report("raw_stall");

      for (int i = 0; i < 300; i++) begin
         kind = $urandom_range(0, 2);
         sel  = $urandom_range(0, 4);
         case (sel)
            0: a = make_addr(3'd0, 7'd0);
            1: a = rand_desc_addr();
            2: a = rand_unused_addr();
            3: a = rand_page_addr();
            default: a = make_addr(3'd0, 7'(`CFG_RAW_WORD));
         endcase
         xfer(kind, a);
      end
      xfer(0, '0);                 // flush the last data phase
      report("mixed");

      $display("%0d checks, %0d errors, %0d cycles", checks, errors, cycles);
      if (errors == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

/* tb/tb_clkgen.sv */
module tb_clkgen (
   output logic hclk,
   output logic hresetn
);

   timeunit 1ns;
   timeprecision 1ps;

   initial hclk = 1'b0;
   always #4 hclk = ~hclk;   // 8 ns period

   // reset low for the first 8 cycles
   initial begin
      hresetn = 1'b0;
      repeat (8) @(posedge hclk);
      hresetn <= 1'b1;
   end

endmodule
